//--- files.f
+incdir+rtl
rtl/sys_defs_pkg.sv
rtl/mc_cfg_if.sv
rtl/mc_config_regs.sv
rtl/mem_tag_queue.sv
rtl/memory_controller.sv
rtl/vector_sram.sv
rtl/attn_mem_top.sv
verification/tb_mem_model.sv
verification/attn_mem_sva.sv
verification/tb_attn_mem.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_attn_mem
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_attn_mem.sv
// Directed testbench for the attention memory front end with a tagged memory model
`timescale 1ns/1ps
`include "attn_defines.svh"

module tb_attn_mem import sys_defs_pkg::*; ();

    localparam int SEQ        = `MAX_SEQ_LEN;
    localparam int BPV        = `MEM_BLOCKS_PER_VECTOR;
    localparam int BLK_BYTES  = `MEM_BLOCK_SIZE_BYTES;
    localparam int VEC_BYTES  = BPV * BLK_BYTES;
    localparam int RD_W       = $clog2(SEQ);
    localparam int MEM_LAT    = 3;
    localparam int MAX_GAP    = 3;     // Idle cycles between O offers
    localparam int NUM_RUNS   = 3;
    // Per block 16 cycles covers heavy rejection
    localparam int RUN_CYCLES = 4 * SEQ * (BPV * 16 + MEM_LAT + MAX_GAP + 4);
    localparam int WATCHDOG_NS = (NUM_RUNS * RUN_CYCLES + 200) * 8;

    logic clk = 1'b0;
    logic rst, cfg_we, cfg_start, o_vld, o_rdy, busy, done;
    CFG_SEL_T cfg_sel;
    ADDR cfg_wdata, proc2mem_addr;
    MEM_TAG trans_tag, data_tag;
    MEM_BLOCK mem2proc_data, proc2mem_data;
    MEM_COMMAND proc2mem_command;
    VECTOR_T o_vector, k_rd_data, v_rd_data, q_rd_data;
    logic [RD_W-1:0] k_rd_addr, v_rd_addr, q_rd_addr;
    int reject_pct;
    int err_cnt, chk_cnt;
    VECTOR_T o_sent [SEQ];   // O vectors in offer order

    always #4 clk = ~clk;    // 8 ns period

    attn_mem_top dut (.clk, .rst, .cfg_we, .cfg_sel, .cfg_wdata, .cfg_start,
                      .mem2proc_transaction_tag(trans_tag), .mem2proc_data_tag(data_tag),
                      .mem2proc_data, .proc2mem_command, .proc2mem_addr, .proc2mem_data,
                      .o_vld, .o_vector, .o_rdy, .k_rd_addr, .k_rd_data, .v_rd_addr, .v_rd_data,
                      .q_rd_addr, .q_rd_data, .busy, .done);

    tb_mem_model #(.LATENCY(MEM_LAT)) mem_model (.clk, .rst, .reject_pct, .proc2mem_command,
                      .proc2mem_addr, .proc2mem_data, .mem2proc_transaction_tag(trans_tag),
                      .mem2proc_data_tag(data_tag), .mem2proc_data);

    bind memory_controller attn_mem_sva u_sva (.clk, .rst, .phase(phase), .proc2mem_command,
                      .proc2mem_addr, .mem2proc_transaction_tag, .k_vld, .v_vld, .q_vld,
                      .k_rdy, .v_rdy, .q_rdy, .o_rdy);

    // ------------------------------
    // Checks and expected values
    // ------------------------------
    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        chk_cnt++;
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_vec(input string name, input VECTOR_T exp, input VECTOR_T act);
        chk_cnt++;
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    // Vector idx of a region, block 0 at the lower address
    function automatic VECTOR_T expect_vector(input ADDR base, input int idx);
        VECTOR_T v;
        for (int b = 0; b < BPV; b++) begin
            v[b] = mem_model.peek(base + ADDR'(idx * VEC_BYTES + b * BLK_BYTES));
        end
        return v;
    endfunction

    // SRAM contents, O region and the ordered command log of one run
    task automatic check_run(input string name, input int log_start,
                             input ADDR kb, input ADDR vb, input ADDR qb, input ADDR ob);
        ADDR bases [4];
        int  n;
        bases = '{kb, vb, qb, ob};
        for (int i = 0; i < SEQ; i++) begin
            k_rd_addr = RD_W'(i);
            v_rd_addr = RD_W'(i);
            q_rd_addr = RD_W'(i);
            @(negedge clk);                  // Registered read
            check_vec({name, ": K entry"}, expect_vector(kb, i), k_rd_data);
            check_vec({name, ": V entry"}, expect_vector(vb, i), v_rd_data);
            check_vec({name, ": Q entry"}, expect_vector(qb, i), q_rd_data);
            check_vec({name, ": O region"}, o_sent[i], expect_vector(ob, i));
        end
        check_word({name, ": log length"}, 4 * SEQ * BPV, mem_model.log_addr.size() - log_start);
        n = log_start;
        for (int m = 0; m < 4; m++) begin    // K, V, Q loads then O stores
            for (int v = 0; v < SEQ; v++) begin
                for (int b = 0; b < BPV; b++) begin
                    if (n < mem_model.log_addr.size()) begin
                        check_word({name, ": log address"},
                                   bases[m] + ADDR'(v * VEC_BYTES + b * BLK_BYTES),
                                   mem_model.log_addr[n]);
                        check_word({name, ": log command"},
                                   (m == 3) ? 32'(MEM_STORE) : 32'(MEM_LOAD),
                                   32'(mem_model.log_cmd[n]));
                    end
                    n++;
                end
            end
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic write_base(input CFG_SEL_T sel, input ADDR value);
        cfg_we    = 1'b1;
        cfg_sel   = sel;
        cfg_wdata = value;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic start_run();
        cfg_start = 1'b1;
        @(negedge clk);
        cfg_start = 1'b0;
        while (!busy) @(negedge clk);
    endtask

    task automatic offer_o(input VECTOR_T v);
        repeat ($urandom_range(MAX_GAP, 0)) @(negedge clk);
        o_vector = v;
        o_vld    = 1'b1;
        while (!o_rdy) @(negedge clk);       // Taken at the next rising edge
        @(negedge clk);
        o_vld = 1'b0;
    endtask

    // Feed all O vectors, then wait for done
    task automatic finish_run(input string name, input int log_start);
        int stores;
        for (int i = 0; i < SEQ; i++) begin
            o_sent[i] = {$urandom, $urandom, $urandom, $urandom};
            offer_o(o_sent[i]);
        end
        while (!done) @(negedge clk);
        stores = 0;
        for (int n = log_start; n < mem_model.log_cmd.size(); n++) begin
            if (mem_model.log_cmd[n] == MEM_STORE) stores++;
        end
        check_word({name, ": stores seen at done"}, SEQ * BPV, stores);
        check_word({name, ": busy at done"}, 0, 32'(busy));
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_reset_state();
        check_word("reset_state: done", 0, 32'(done));
        check_word("reset_state: busy", 0, 32'(busy));
        check_word("reset_state: o_rdy", 0, 32'(o_rdy));
        check_word("reset_state: command", 32'(MEM_NONE), 32'(proc2mem_command));
    endtask

    task automatic test_default_run();
        int log_start;
        log_start = mem_model.log_addr.size();
        start_run();
        finish_run("default_run", log_start);
        check_run("default_run", log_start, `DEF_K_BASE, `DEF_V_BASE, `DEF_Q_BASE, `DEF_O_BASE);
    endtask

    task automatic test_rebase();
        int log_start;
        write_base(CFG_K_BASE, 32'h0000_0400);
        write_base(CFG_V_BASE, 32'h0000_0500);
        write_base(CFG_Q_BASE, 32'h0000_0600);
        write_base(CFG_O_BASE, 32'h0000_0700);
        log_start = mem_model.log_addr.size();
        start_run();
        write_base(CFG_K_BASE, 32'h0000_0F00);    // Locked out while busy
        finish_run("rebase", log_start);
        check_run("rebase", log_start, 32'h400, 32'h500, 32'h600, 32'h700);
    endtask

    // Half the commands refused, bases still from the rebase test
    task automatic test_rejections();
        int log_start;
        reject_pct = 50;
        log_start  = mem_model.log_addr.size();
        start_run();
        finish_run("rejections", log_start);
        check_run("rejections", log_start, 32'h400, 32'h500, 32'h600, 32'h700);
        reject_pct = 0;
    endtask

    initial begin
        void'($urandom(32'hc7a8_d052));
        err_cnt    = 0;
        chk_cnt    = 0;
        rst        = 1'b1;
        cfg_we     = 1'b0;
        cfg_sel    = CFG_K_BASE;
        cfg_wdata  = '0;
        cfg_start  = 1'b0;
        o_vld      = 1'b0;
        o_vector   = '0;
        k_rd_addr  = '0;
        v_rd_addr  = '0;
        q_rd_addr  = '0;
        reject_pct = 0;
        mem_model.fill();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_default_run();
        test_rebase();
        test_rejections();
        $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Hang guard sized from the run length
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, a run did not reach done", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- verification/attn_mem_sva.sv
// Protocol checks on the memory controller ports and phase
`timescale 1ns/1ps

module attn_mem_sva import sys_defs_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic [2:0] phase,   // Controller phase code
    input MEM_COMMAND proc2mem_command,
    input ADDR        proc2mem_addr,
    input MEM_TAG     mem2proc_transaction_tag,
    input logic       k_vld,
    input logic       v_vld,
    input logic       q_vld,
    input logic       k_rdy,
    input logic       v_rdy,
    input logic       q_rdy,
    input logic       o_rdy
);

    localparam logic [2:0] IDLE_CODE  = 3'd0;
    localparam logic [2:0] DRAIN_CODE = 3'd4;

    // ------------------------------
    // Memory port
    // ------------------------------
    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        (phase == IDLE_CODE) |-> (proc2mem_command == MEM_NONE))
        else $error("Memory command issued while controller idle");

    a_reject_repeat: assert property (@(posedge clk) disable iff (rst)
        (proc2mem_command != MEM_NONE && mem2proc_transaction_tag == '0)
        |=> (proc2mem_command == $past(proc2mem_command)
             && proc2mem_addr == $past(proc2mem_addr)))
        else $error("Rejected command not repeated at the same address");

    // SRAM hand-off holds until taken
    a_k_hold: assert property (@(posedge clk) disable iff (rst) k_vld && !k_rdy |=> k_vld)
        else $error("K vld dropped before rdy");
    a_v_hold: assert property (@(posedge clk) disable iff (rst) v_vld && !v_rdy |=> v_vld)
        else $error("V vld dropped before rdy");
    a_q_hold: assert property (@(posedge clk) disable iff (rst) q_vld && !q_rdy |=> q_vld)
        else $error("Q vld dropped before rdy");

    a_o_rdy_drain: assert property (@(posedge clk) disable iff (rst)
        o_rdy |-> (phase == DRAIN_CODE))
        else $error("o_rdy high outside the drain phase");

endmodule

//--- verification/tb_mem_model.sv
// Tagged memory model with random rejection, in-order fixed-latency load returns and an access log
`timescale 1ns/1ps
`include "attn_defines.svh"

module tb_mem_model import sys_defs_pkg::*; #(
    parameter int LATENCY = 3,    // Cycles from accepted load to data
    parameter int WORDS   = 512   // 64-bit words, 4 KB
) (
    input  logic       clk,
    input  logic       rst,
    input  int         reject_pct,   // Percent of cycles that refuse a command
    input  MEM_COMMAND proc2mem_command,
    input  ADDR        proc2mem_addr,
    input  MEM_BLOCK   proc2mem_data,
    output MEM_TAG     mem2proc_transaction_tag,
    output MEM_TAG     mem2proc_data_tag,
    output MEM_BLOCK   mem2proc_data
);

    localparam int IDX_W = $clog2(WORDS);

    MEM_BLOCK         mem [WORDS];
    MEM_TAG           next_tag;          // Tag handed to the next accepted command
    logic             reject;            // Rolled once per cycle
    logic [IDX_W-1:0] idx;
    MEM_TAG           ret_tag [LATENCY];  // Return pipeline, oldest at the end
    MEM_BLOCK         ret_data [LATENCY];
    MEM_COMMAND       log_cmd [$];       // Accepted commands in order
    ADDR              log_addr [$];

    assign idx = proc2mem_addr[IDX_W+2:3];
    assign mem2proc_transaction_tag = (proc2mem_command != MEM_NONE && !reject) ? next_tag : '0;
    assign mem2proc_data_tag = ret_tag[LATENCY-1];
    assign mem2proc_data     = ret_data[LATENCY-1];

    // Word at a byte address, for expected values
    function automatic MEM_BLOCK peek(input ADDR a);
        return mem[a[IDX_W+2:3]];
    endfunction

    // Random contents, every word drawn separately
    task automatic fill();
        for (int i = 0; i < WORDS; i++) begin
            mem[i] <= {$urandom, $urandom};
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            next_tag <= 4'd1;
            reject   <= 1'b0;
            for (int i = 0; i < LATENCY; i++) begin
                ret_tag[i]  <= '0;
                ret_data[i] <= '0;
            end
        end else begin
            reject      <= ($urandom_range(99, 0) < reject_pct);
            ret_tag[0]  <= '0;                      // Idle slot unless a load is taken
            ret_data[0] <= '0;
            for (int i = 1; i < LATENCY; i++) begin
                ret_tag[i]  <= ret_tag[i-1];
                ret_data[i] <= ret_data[i-1];
            end
            if (mem2proc_transaction_tag != '0) begin
                next_tag <= (next_tag == MEM_TAG'(`NUM_MEM_TAGS)) ? 4'd1 : next_tag + 1'b1;
                log_cmd.push_back(proc2mem_command);
                log_addr.push_back(proc2mem_addr);
                if (proc2mem_command == MEM_LOAD) begin
                    ret_tag[0]  <= mem2proc_transaction_tag;
                    ret_data[0] <= mem[idx];
                end else begin
                    mem[idx] <= proc2mem_data;      // Stores return nothing
                end
            end
        end
    end

endmodule

//--- rtl/attn_mem_top.sv
// Attention memory front end top level, config registers, controller, tag queue and SRAMs
`timescale 1ns/1ps
`include "attn_defines.svh"

module attn_mem_top import sys_defs_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    // Configuration
    input  logic                            cfg_we,
    input  CFG_SEL_T                        cfg_sel,
    input  ADDR                             cfg_wdata,
    input  logic                            cfg_start,
    // Tagged memory port
    input  MEM_TAG                          mem2proc_transaction_tag,
    input  MEM_TAG                          mem2proc_data_tag,
    input  MEM_BLOCK                        mem2proc_data,
    output MEM_COMMAND                      proc2mem_command,
    output ADDR                             proc2mem_addr,
    output MEM_BLOCK                        proc2mem_data,
    // O stream from the compute engine
    input  logic                            o_vld,
    input  VECTOR_T                         o_vector,
    output logic                            o_rdy,
    // SRAM reads
    input  logic [$clog2(`MAX_SEQ_LEN)-1:0] k_rd_addr,
    output VECTOR_T                         k_rd_data,
    input  logic [$clog2(`MAX_SEQ_LEN)-1:0] v_rd_addr,
    output VECTOR_T                         v_rd_data,
    input  logic [$clog2(`MAX_SEQ_LEN)-1:0] q_rd_addr,
    output VECTOR_T                         q_rd_data,
    output logic                            busy,
    output logic                            done
);

    logic    tag_push, tag_hit;
    logic    k_vld, v_vld, q_vld;
    logic    k_rdy, v_rdy, q_rdy;
    VECTOR_T loaded_vector;     // Shared by all three SRAM write ports

    mc_cfg_if cfg_bus ();

    assign busy = cfg_bus.busy;

    mc_config_regs u_cfg_regs (.clk, .rst, .cfg_we, .cfg_sel, .cfg_wdata, .cfg_start,
                               .cfg(cfg_bus.regs));

    mem_tag_queue u_tag_queue (.clk, .rst, .clr(cfg_bus.start), .push(tag_push),
                               .push_tag(mem2proc_transaction_tag), .data_tag(mem2proc_data_tag),
                               .hit(tag_hit), .empty());

    memory_controller u_mem_ctrl (.clk, .rst, .cfg(cfg_bus.ctrl), .mem2proc_transaction_tag,
                                  .mem2proc_data_tag, .mem2proc_data, .proc2mem_command,
                                  .proc2mem_addr, .proc2mem_data, .tag_push, .tag_hit,
                                  .k_vld, .v_vld, .q_vld, .k_rdy, .v_rdy, .q_rdy,
                                  .loaded_vector, .o_vld, .o_vector, .o_rdy, .done);

    // Each SRAM restarts its fill on the start pulse
    vector_sram u_k_sram (.clk, .rst, .clr(cfg_bus.start), .wr_vld(k_vld), .wr_rdy(k_rdy),
                          .wr_data(loaded_vector), .rd_addr(k_rd_addr), .rd_data(k_rd_data));
    vector_sram u_v_sram (.clk, .rst, .clr(cfg_bus.start), .wr_vld(v_vld), .wr_rdy(v_rdy),
                          .wr_data(loaded_vector), .rd_addr(v_rd_addr), .rd_data(v_rd_data));
    vector_sram u_q_sram (.clk, .rst, .clr(cfg_bus.start), .wr_vld(q_vld), .wr_rdy(q_rdy),
                          .wr_data(loaded_vector), .rd_addr(q_rd_addr), .rd_data(q_rd_data));

endmodule

//--- rtl/vector_sram.sv
// Vector store filled at successive entries, with a registered indexed read port
`timescale 1ns/1ps
`include "attn_defines.svh"

module vector_sram import sys_defs_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            clr,      // Restart fill at entry 0
    input  logic                            wr_vld,
    output logic                            wr_rdy,
    input  VECTOR_T                         wr_data,
    input  logic [$clog2(`MAX_SEQ_LEN)-1:0] rd_addr,
    output VECTOR_T                         rd_data   // One cycle after rd_addr
);

    localparam int DEPTH = `MAX_SEQ_LEN;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    VECTOR_T          mem [DEPTH];
    logic [CNT_W-1:0] fill_cnt;
    logic             wr_en;

    assign wr_rdy = (fill_cnt != CNT_W'(DEPTH));  // Stops once every entry is written
    assign wr_en  = wr_vld && wr_rdy && !clr;

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            fill_cnt <= '0;
        end else if (wr_en) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    // Storage and read register
    always_ff @(posedge clk) begin
        if (wr_en) mem[fill_cnt[IDX_W-1:0]] <= wr_data;
        rd_data <= mem[rd_addr];
    end

endmodule

//--- rtl/memory_controller.sv
// Phase FSM loading K, V, Q vectors from tagged memory and draining O vectors back
`timescale 1ns/1ps
`include "attn_defines.svh"

module memory_controller import sys_defs_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    mc_cfg_if.ctrl     cfg,
    input  MEM_TAG     mem2proc_transaction_tag,  // Nonzero means accepted
    input  MEM_TAG     mem2proc_data_tag,
    input  MEM_BLOCK   mem2proc_data,
    output MEM_COMMAND proc2mem_command,
    output ADDR        proc2mem_addr,
    output MEM_BLOCK   proc2mem_data,
    output logic       tag_push,   // Accepted load tag into the queue
    input  logic       tag_hit,    // Returned data belongs to oldest load
    output logic       k_vld,
    output logic       v_vld,
    output logic       q_vld,
    input  logic       k_rdy,
    input  logic       v_rdy,
    input  logic       q_rdy,
    output VECTOR_T    loaded_vector,
    input  logic       o_vld,
    input  VECTOR_T    o_vector,
    output logic       o_rdy,
    output logic       done
);

    localparam int  BPV       = `MEM_BLOCKS_PER_VECTOR;
    localparam int  BLK_W     = $clog2(BPV);
    localparam int  VEC_W     = $clog2(`MAX_SEQ_LEN);
    localparam ADDR BLK_BYTES = ADDR'(`MEM_BLOCK_SIZE_BYTES);
    localparam ADDR VEC_BYTES = ADDR'(BPV * `MEM_BLOCK_SIZE_BYTES);

    typedef enum logic [2:0] {
        PH_IDLE, PH_LOAD_K, PH_LOAD_V, PH_LOAD_Q, PH_DRAIN_O, PH_DONE
    } phase_e;

    phase_e           phase;
    phase_e           next_phase;
    logic [VEC_W-1:0] vec_idx;    // Vector within current phase
    logic [BLK_W:0]   iss_cnt;    // Blocks issued, loads or stores
    logic [BLK_W:0]   fill_cnt;   // Blocks held in vec_buf
    VECTOR_T          vec_buf;    // Assembly buffer
    ADDR              phase_base;
    logic load_phase, buf_full, buf_empty, last_vec;
    logic accepted, vec_xfer, store_last, o_take;

    assign load_phase = (phase == PH_LOAD_K) || (phase == PH_LOAD_V) || (phase == PH_LOAD_Q);
    assign buf_full   = (fill_cnt == (BLK_W+1)'(BPV));
    assign buf_empty  = (fill_cnt == '0);
    assign last_vec   = (vec_idx == VEC_W'(`MAX_SEQ_LEN-1));

    // ------------------------------
    // Handshakes and status
    // ------------------------------
    assign k_vld    = (phase == PH_LOAD_K) && buf_full;
    assign v_vld    = (phase == PH_LOAD_V) && buf_full;
    assign q_vld    = (phase == PH_LOAD_Q) && buf_full;
    assign vec_xfer = (k_vld && k_rdy) || (v_vld && v_rdy) || (q_vld && q_rdy);
    assign o_rdy    = (phase == PH_DRAIN_O) && buf_empty;  // Take O only into an empty buffer
    assign o_take   = o_vld && o_rdy;
    assign loaded_vector = vec_buf;
    assign done     = (phase == PH_DONE);
    assign cfg.busy = (phase != PH_IDLE) && (phase != PH_DONE);

    // ------------------------------
    // Memory port
    // ------------------------------
    always_comb begin
        unique case (phase)
            PH_LOAD_K:  phase_base = cfg.k_base;
            PH_LOAD_V:  phase_base = cfg.v_base;
            PH_LOAD_Q:  phase_base = cfg.q_base;
            PH_DRAIN_O: phase_base = cfg.o_base;
            default:    phase_base = '0;
        endcase

        proc2mem_command = MEM_NONE;
        proc2mem_data    = '0;
        // Loads run ahead until every block of the vector is in flight
        if (load_phase && (iss_cnt != (BLK_W+1)'(BPV))) begin
            proc2mem_command = MEM_LOAD;
        end
        if ((phase == PH_DRAIN_O) && buf_full) begin
            proc2mem_command = MEM_STORE;
            proc2mem_data    = vec_buf[iss_cnt[BLK_W-1:0]];
        end
    end

    // Counters hold on rejection so the same address is repeated
    assign proc2mem_addr = phase_base + ADDR'(vec_idx) * VEC_BYTES + ADDR'(iss_cnt) * BLK_BYTES;
    assign accepted   = (proc2mem_command != MEM_NONE) && (mem2proc_transaction_tag != '0);
    assign tag_push   = accepted && (proc2mem_command == MEM_LOAD);
    assign store_last = accepted && (proc2mem_command == MEM_STORE)
                        && (iss_cnt == (BLK_W+1)'(BPV-1));

    // ------------------------------
    // Phase sequencing
    // ------------------------------
    always_comb begin
        next_phase = phase;
        unique case (phase)
            PH_IDLE,
            PH_DONE:    if (cfg.start) next_phase = PH_LOAD_K;
            PH_LOAD_K:  if (vec_xfer && last_vec) next_phase = PH_LOAD_V;
            PH_LOAD_V:  if (vec_xfer && last_vec) next_phase = PH_LOAD_Q;
            PH_LOAD_Q:  if (vec_xfer && last_vec) next_phase = PH_DRAIN_O;
            PH_DRAIN_O: if (store_last && last_vec) next_phase = PH_DONE;  // Last store seen
            default:    next_phase = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= PH_IDLE;
            vec_idx  <= '0;
            iss_cnt  <= '0;
            fill_cnt <= '0;
        end else begin
            phase <= next_phase;
            if (cfg.start) begin
                vec_idx  <= '0;
                iss_cnt  <= '0;
                fill_cnt <= '0;
            end else begin
                if (tag_push) iss_cnt <= iss_cnt + 1'b1;
                if (load_phase && tag_hit) fill_cnt <= fill_cnt + 1'b1;
                // Vector handed to its SRAM, next one starts
                if (vec_xfer || store_last) begin
                    iss_cnt  <= '0;
                    fill_cnt <= '0;
                    vec_idx  <= last_vec ? '0 : vec_idx + 1'b1;
                end else if (accepted && (proc2mem_command == MEM_STORE)) begin
                    iss_cnt <= iss_cnt + 1'b1;
                end
                if (o_take) begin
                    fill_cnt <= (BLK_W+1)'(BPV);  // Whole O vector at once
                    iss_cnt  <= '0;
                end
            end
        end
    end

    // Buffer fill from memory or from the O stream
    always_ff @(posedge clk) begin
        if (o_take) begin
            vec_buf <= o_vector;
        end else if (load_phase && tag_hit) begin
            vec_buf[fill_cnt[BLK_W-1:0]] <= mem2proc_data;  // In-order returns
        end
    end

endmodule

//--- rtl/mem_tag_queue.sv
// Outstanding load tag FIFO, matches returned data tags against the oldest entry
`timescale 1ns/1ps
`include "attn_defines.svh"

module mem_tag_queue import sys_defs_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   clr,       // Flush at run start
    input  logic   push,      // Load accepted this cycle
    input  MEM_TAG push_tag,  // Tag the memory gave it
    input  MEM_TAG data_tag,  // Tag on returning data
    output logic   hit,
    output logic   empty
);

    localparam int DEPTH = `NUM_MEM_TAGS + 1;  // One spare slot tells full from empty
    localparam int PTR_W = $clog2(DEPTH);

    MEM_TAG           tags [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;

    assign empty = (head == tail);

    // Zero data tag never matches, memory uses it for idle cycles
    assign hit = !empty && (data_tag != '0) && (data_tag == tags[head]);

    // ------------------------------
    // Pointers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst || clr) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (push) begin
                tail <= (tail == PTR_W'(DEPTH-1)) ? '0 : tail + 1'b1;
            end
            if (hit) begin  // Pop the oldest on match
                head <= (head == PTR_W'(DEPTH-1)) ? '0 : head + 1'b1;
            end
        end
    end

    // Tag storage
    always_ff @(posedge clk) begin
        if (push) begin
            tags[tail] <= push_tag;
        end
    end

endmodule

//--- rtl/mc_config_regs.sv
// Base address registers with run lock and start pulse generation
`timescale 1ns/1ps
`include "attn_defines.svh"

module mc_config_regs import sys_defs_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     cfg_we,     // Base address write strobe
    input  CFG_SEL_T cfg_sel,    // Which base to write
    input  ADDR      cfg_wdata,
    input  logic     cfg_start,  // Run request that may be held
    mc_cfg_if.regs   cfg
);

    logic locked;

    // No writes or new starts from the pulse cycle until the run ends
    assign locked = cfg.busy || cfg.start;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.k_base <= ADDR'(`DEF_K_BASE);
            cfg.v_base <= ADDR'(`DEF_V_BASE);
            cfg.q_base <= ADDR'(`DEF_Q_BASE);
            cfg.o_base <= ADDR'(`DEF_O_BASE);
            cfg.start  <= 1'b0;
        end else begin
            cfg.start <= cfg_start && !locked;  // Lock keeps this to a single cycle
            if (cfg_we && !locked) begin
                unique case (cfg_sel)
                    CFG_K_BASE: cfg.k_base <= cfg_wdata;
                    CFG_V_BASE: cfg.v_base <= cfg_wdata;
                    CFG_Q_BASE: cfg.q_base <= cfg_wdata;
                    CFG_O_BASE: cfg.o_base <= cfg_wdata;
                endcase
            end
        end
    end

endmodule

//--- rtl/mc_cfg_if.sv
// Configuration link between the base registers and the memory controller
`timescale 1ns/1ps

interface mc_cfg_if import sys_defs_pkg::*; ();

    ADDR  k_base;   // Phase base addresses
    ADDR  v_base;
    ADDR  q_base;
    ADDR  o_base;
    logic start;    // Single-cycle run request
    logic busy;     // Run in progress

    // Register side
    modport regs (output k_base, v_base, q_base, o_base, start, input busy);

    // Controller side
    modport ctrl (input k_base, v_base, q_base, o_base, start, output busy);

endinterface

//--- rtl/sys_defs_pkg.sv
// Shared address, tag, memory block, command and vector types
`include "attn_defines.svh"

package sys_defs_pkg;

    typedef logic [31:0] ADDR;      // Byte address
    typedef logic [3:0]  MEM_TAG;   // Zero means rejected or no data

    // One memory word, whole or per byte
    typedef union packed {
        logic [63:0]     dword;
        logic [7:0][7:0] byte_level;
    } MEM_BLOCK;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'h0,
        MEM_LOAD  = 2'h1,
        MEM_STORE = 2'h2
    } MEM_COMMAND;

    // Block 0 sits in the low bits
    typedef MEM_BLOCK [`MEM_BLOCKS_PER_VECTOR-1:0] VECTOR_T;

    // Register select for base address writes
    typedef enum logic [1:0] {
        CFG_K_BASE = 2'h0,
        CFG_V_BASE = 2'h1,
        CFG_Q_BASE = 2'h2,
        CFG_O_BASE = 2'h3
    } CFG_SEL_T;

endpackage

//--- rtl/attn_defines.svh
// Size and default address definitions for the attention memory front end
`ifndef ATTN_DEFINES_SVH
`define ATTN_DEFINES_SVH

// ------------------------------
// Memory and vector geometry
// ------------------------------
`define MEM_BLOCK_SIZE_BYTES  8     // Bytes per 64-bit memory block
`define MEM_BLOCKS_PER_VECTOR 2     // Blocks assembled into one vector
`define MAX_SEQ_LEN           4     // Vectors per K, V, Q or O matrix
`define NUM_MEM_TAGS          15    // Nonzero tag values the memory hands out

// ------------------------------
// Reset base addresses
// ------------------------------
`define DEF_K_BASE 32'h0000_0000
`define DEF_V_BASE 32'h0000_0100
`define DEF_Q_BASE 32'h0000_0200
`define DEF_O_BASE 32'h0000_0300

`endif
